// File: filelist.f
src/useless_pkg.sv
src/mode_decoder.sv
src/servo_planner.sv
src/motor_planner.sv
src/status_display.sv
src/useless_box_top.sv
tb/tb_useless_box.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the useless box testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_useless_box \
    -f filelist.f -o sim_useless_box > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_useless_box 2>&1 | tee sim.log
grep -q "TEST FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TEST OK" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
echo "Simulation passed"

// File: tb/tb_useless_box.sv
// ##########################################################
// Useless box testbench
// LFSR stimulus checked against reference models of mode,
// relay, servo, motor and display behaviour
// ##########################################################

`timescale 1ns/1ns

module tb_useless_box;

    import useless_pkg::*;

    localparam int RESET_CYCLES   = 4;
    localparam int RUN_CYCLES     = 2000;
    // Stimulus length plus ten percent
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 10;

    logic       clk;
    logic       rst;
    logic       mode_pulse;
    ub_sel_t    wanted_ub;
    logic       sw0;
    logic [3:0] ir_near;
    dist_t      dist_left;
    dist_t      dist_right;
    logic       cmd_switch;
    logic       cmd_forward;
    logic       cmd_backward;
    logic       cmd_left;
    logic       cmd_right;
    logic       ble_err;
    logic       relay;
    logic       servo_enable;
    logic       servo_sel;
    servo_amt_t servo_amount;
    logic [1:0] motor_cw;
    logic [1:0] motor_ccw;
    seg_t       seg0;
    seg_t       seg1;
    seg_t       seg2;
    seg_t       seg3;

    logic [15:0] lfsr_state = 16'd47962;
    // Expected register contents, from the pulses and commands applied
    mode_t       exp_mode = MODE_NS;
    logic        exp_sw_cmd = 1'b0;
    int          cycle_count = 0;

    useless_box_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int n, output logic [19:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[18:0], lfsr_state[0]};
        end
    endtask

    function automatic ub_style_t decode_style(input ub_sel_t code);
        if (code == 3'b001) return UB_CLASSIC;
        if (code == 3'b010) return UB_DODGE;
        if (code == 3'b100) return UB_ADVANCE;
        return UB_INVALID;
    endfunction

    // Arm lift from IR and the two distances
    function automatic servo_amt_t ref_closer(input logic [3:0] ir, input dist_t dl,
                                              input dist_t dr);
        int l;
        int r;
        int lift;
        l = int'(dl);
        r = int'(dr) + int'(DIST_SKEW);
        if (ir != 4'd0) return SERVO_FULL;
        if (l > int'(GOOD_DIS) && r > int'(GOOD_DIS)) return '0;
        lift = ((l < r) ? l : r) * int'(SERVO_GAIN);
        if (lift < int'(SERVO_LIMIT)) return servo_amt_t'(lift);
        return SERVO_FULL;
    endfunction

    // Packed as enable, side, amount
    function automatic logic [6:0] ref_servo(input mode_t m, input ub_style_t st,
                                             input logic cmd, input logic sw,
                                             input servo_amt_t closer);
        logic push;
        push = (m == MODE_NS) || (m == MODE_UB && (st == UB_CLASSIC || st == UB_ADVANCE));
        if (cmd != sw) return push ? {1'b1, ~sw, SERVO_FULL} : {1'b1, sw, 5'd0};
        if (m != MODE_UB) return {1'b0, ~sw, 5'd0};
        if (st == UB_ADVANCE) return {1'b1, ~sw, closer};
        return {1'b1, sw, 5'd0};
    endfunction

    // Packed as cw, ccw; cmd order is forward, backward, left, right
    function automatic logic [3:0] ref_motor(input mode_t m, input ub_style_t st,
                                             input dist_t dl, input dist_t dr,
                                             input logic [3:0] cmd, input logic err);
        int l;
        int r;
        l = int'(dl);
        r = int'(dr) + int'(DIST_SKEW);
        if (m == MODE_UB && st == UB_DODGE) begin
            if (l < int'(DODGE_NEAR) || r < int'(DODGE_NEAR)) return 4'b0000;
            if (l > int'(DODGE_FAR) && r > int'(DODGE_FAR)) return 4'b0000;
            // Hand nearer the right, roll ccw
            return (l > r) ? 4'b0011 : 4'b1100;
        end
        if (m != MODE_UC || err) return 4'b0000;
        if (cmd[3]) return 4'b1100;
        if (cmd[2]) return 4'b0011;
        // Single wheel turns, both cw
        if (cmd[1]) return 4'b1000;
        if (cmd[0]) return 4'b0100;
        return 4'b0000;
    endfunction

    function automatic seg_t glyph_seg(input glyph_t g);
        seg_t s;
        s = 7'b1111111;
        if (g == 4'd0) s = 7'b1000000;
        if (g == 4'd1) s = 7'b1111001;
        if (g == 4'd2) s = 7'b0100100;
        if (g == GLYPH_E) s = 7'b0000110;
        if (g == GLYPH_R) s = 7'b0101111;
        return s;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_mode(input mode_t got, input mode_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: mode got %0d expected %0d",
                                $time, got, exp));
    endtask

    task automatic check_relay(input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: relay got %b expected %b",
                                $time, got, exp));
    endtask

    task automatic check_servo(input logic en, input logic sel, input servo_amt_t amt,
                               input logic exp_en, input logic exp_sel,
                               input servo_amt_t exp_amt);
        if (en !== exp_en)
            abort_run($sformatf("CHECK FAILED at %0t ns: servo_enable got %b expected %b",
                                $time, en, exp_en));
        if (sel !== exp_sel)
            abort_run($sformatf("CHECK FAILED at %0t ns: servo_sel got %b expected %b",
                                $time, sel, exp_sel));
        if (amt !== exp_amt)
            abort_run($sformatf("CHECK FAILED at %0t ns: servo_amount got %0d expected %0d",
                                $time, amt, exp_amt));
    endtask

    task automatic check_motor(input string name, input logic [1:0] got,
                               input logic [1:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
                                $time, name, got, exp));
    endtask

    task automatic check_seg(input string name, input seg_t got, input seg_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s got %b expected %b",
                                $time, name, got, exp));
    endtask

    // Replays the last rising edge on the model registers
    task automatic update_model();
        if (rst) begin
            exp_mode   = MODE_NS;
            exp_sw_cmd = sw0;
        end else begin
            if (exp_mode == MODE_NS && cmd_switch && !ble_err)
                exp_sw_cmd = ~exp_sw_cmd;
            if (mode_pulse)
                exp_mode = (exp_mode == MODE_NS) ? MODE_UB :
                           (exp_mode == MODE_UB) ? MODE_UC : MODE_NS;
        end
    endtask

    task automatic check_outputs();
        ub_style_t  st;
        logic [6:0] sv;
        logic [3:0] mt;
        logic       flag;
        st = decode_style(wanted_ub);
        check_mode(DUT.mode, exp_mode);
        check_relay(relay, (exp_mode == MODE_NS) ? sw0 : 1'b0);
        sv = ref_servo(exp_mode, st, exp_sw_cmd, sw0,
                       ref_closer(ir_near, dist_left, dist_right));
        check_servo(servo_enable, servo_sel, servo_amount, sv[6], sv[5], sv[4:0]);
        mt = ref_motor(exp_mode, st, dist_left, dist_right,
                       {cmd_forward, cmd_backward, cmd_left, cmd_right}, ble_err);
        check_motor("motor_cw", motor_cw, mt[3:2]);
        check_motor("motor_ccw", motor_ccw, mt[1:0]);
        // Bad selection in UB, link error elsewhere
        flag = (exp_mode == MODE_UB) ? (st == UB_INVALID) : ble_err;
        check_seg("seg0", seg0, glyph_seg(glyph_t'(exp_mode)));
        check_seg("seg1", seg1, glyph_seg(flag ? GLYPH_R : GLYPH_BLANK));
        check_seg("seg2", seg2, glyph_seg(flag ? GLYPH_R : GLYPH_BLANK));
        check_seg("seg3", seg3, glyph_seg(flag ? GLYPH_E : GLYPH_BLANK));
    endtask

    // Mostly below 32, now and then the full range
    task automatic draw_distance(output dist_t d);
        logic [19:0] r;
        take_bits(3, r);
        if (r[2:0] == 3'd0) take_bits(20, r);
        else take_bits(5, r);
        d = r;
    endtask

    task automatic drive_random();
        logic [19:0] r;
        take_bits(3, r);
        mode_pulse = (r[2:0] == 3'd0);
        take_bits(2, r);
        case (r[1:0])
            2'd0: wanted_ub = 3'b001;
            2'd1: wanted_ub = 3'b010;
            2'd2: wanted_ub = 3'b100;
            default: begin
                take_bits(3, r);
                wanted_ub = ub_sel_t'(r[2:0]);
            end
        endcase
        take_bits(2, r);
        if (r[1:0] == 2'd0) begin
            // Switch ends up where the box wants it
            sw0 = exp_sw_cmd;
        end else begin
            // Rare flip by the user
            take_bits(4, r);
            if (r[3:0] == 4'd0) sw0 = ~sw0;
        end
        take_bits(3, r);
        cmd_switch = (r[2:0] == 3'd0);
        take_bits(3, r);
        ble_err = (r[2:0] == 3'd0);
        take_bits(2, r);
        ir_near = 4'd0;
        if (r[1:0] == 2'd0) begin
            take_bits(4, r);
            ir_near = r[3:0];
        end
        draw_distance(dist_left);
        draw_distance(dist_right);
        take_bits(8, r);
        cmd_forward  = (r[1:0] == 2'd0);
        cmd_backward = (r[3:2] == 2'd0);
        cmd_left     = (r[5:4] == 2'd0);
        cmd_right    = (r[7:6] == 2'd0);
    endtask

    // Sample one ns before the falling edge
    always begin
        @(posedge clk);
        #4;
        update_model();
        check_outputs();
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                                TIMEOUT_CYCLES));
    end

    initial begin
        rst          = 1'b1;
        mode_pulse   = 1'b0;
        wanted_ub    = 3'b001;
        sw0          = 1'b0;
        ir_near      = 4'd0;
        dist_left    = 20'd30;
        dist_right   = 20'd30;
        cmd_switch   = 1'b0;
        cmd_forward  = 1'b0;
        cmd_backward = 1'b0;
        cmd_left     = 1'b0;
        cmd_right    = 1'b0;
        ble_err      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (RUN_CYCLES) begin
            @(negedge clk);
            drive_random();
        end
        // Let the last sample land
        @(negedge clk);
        $display("TEST OK");
        $finish;
    end

endmodule

// File: src/useless_box_top.sv
// ##########################################################
// Useless box top level
// Mode decoder feeding servo and motor planners and display
// ##########################################################

`timescale 1ns/1ns

module useless_box_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    mode_pulse,
    input  useless_pkg::ub_sel_t    wanted_ub,
    input  logic                    sw0,
    input  logic [3:0]              ir_near,
    input  useless_pkg::dist_t      dist_left,
    input  useless_pkg::dist_t      dist_right,
    input  logic                    cmd_switch,
    input  logic                    cmd_forward,
    input  logic                    cmd_backward,
    input  logic                    cmd_left,
    input  logic                    cmd_right,
    input  logic                    ble_err,
    output logic                    relay,
    output logic                    servo_enable,
    output logic                    servo_sel,
    output useless_pkg::servo_amt_t servo_amount,
    output logic [1:0]              motor_cw,
    output logic [1:0]              motor_ccw,
    output useless_pkg::seg_t       seg0,
    output useless_pkg::seg_t       seg1,
    output useless_pkg::seg_t       seg2,
    output useless_pkg::seg_t       seg3
);

    import useless_pkg::*;

    mode_t     mode;
    ub_style_t style;
    logic      sel_err;

    // Mode register and style decode
    mode_decoder u_mode_decoder (
        .clk        (clk),
        .rst        (rst),
        .mode_pulse (mode_pulse),
        .wanted_ub  (wanted_ub),
        .sw0        (sw0),
        .mode       (mode),
        .style      (style),
        .sel_err    (sel_err),
        .relay      (relay)
    );

    servo_planner u_servo_planner (
        .clk          (clk),
        .rst          (rst),
        .sw0          (sw0),
        .cmd_switch   (cmd_switch),
        .ble_err      (ble_err),
        .mode         (mode),
        .style        (style),
        .ir_near      (ir_near),
        .dist_left    (dist_left),
        .dist_right   (dist_right),
        .servo_enable (servo_enable),
        .servo_sel    (servo_sel),
        .servo_amount (servo_amount)
    );

    motor_planner u_motor_planner (
        .mode         (mode),
        .style        (style),
        .dist_left    (dist_left),
        .dist_right   (dist_right),
        .cmd_forward  (cmd_forward),
        .cmd_backward (cmd_backward),
        .cmd_left     (cmd_left),
        .cmd_right    (cmd_right),
        .ble_err      (ble_err),
        .motor_cw     (motor_cw),
        .motor_ccw    (motor_ccw)
    );

    // Result stage, four digits in parallel
    status_display u_status_display (
        .mode    (mode),
        .sel_err (sel_err),
        .ble_err (ble_err),
        .seg0    (seg0),
        .seg1    (seg1),
        .seg2    (seg2),
        .seg3    (seg3)
    );

endmodule

// File: src/status_display.sv
// ##########################################################
// Status display
// Mode digit plus an Err flag on four parallel 7-seg digits
// ##########################################################

`timescale 1ns/1ns

module status_display (
    input  useless_pkg::mode_t mode,
    input  logic               sel_err,
    input  logic               ble_err,
    output useless_pkg::seg_t  seg0,
    output useless_pkg::seg_t  seg1,
    output useless_pkg::seg_t  seg2,
    output useless_pkg::seg_t  seg3
);

    import useless_pkg::*;

    logic   err_flag;
    glyph_t glyph0;
    glyph_t glyph1;
    glyph_t glyph2;
    glyph_t glyph3;

    // Glyph to segment pattern, active low
    function automatic seg_t glyph_to_seg(input glyph_t g);
        seg_t s;
        case (g)
            4'd0:    s = 7'b1000000;
            4'd1:    s = 7'b1111001;
            4'd2:    s = 7'b0100100;
            GLYPH_E: s = 7'b0000110;
            GLYPH_R: s = 7'b0101111;
            // Blank and unused codes
            default: s = 7'b1111111;
        endcase
        return s;
    endfunction

    // UB reports a bad selection, other modes the link state
    assign err_flag = (mode == MODE_UB) ? sel_err : ble_err;

    assign glyph0 = glyph_t'(mode);
    // Leftmost reads E, then r r
    assign glyph3 = err_flag ? GLYPH_E : GLYPH_BLANK;
    assign glyph2 = err_flag ? GLYPH_R : GLYPH_BLANK;
    assign glyph1 = err_flag ? GLYPH_R : GLYPH_BLANK;

    assign seg0 = glyph_to_seg(glyph0);
    assign seg1 = glyph_to_seg(glyph1);
    assign seg2 = glyph_to_seg(glyph2);
    assign seg3 = glyph_to_seg(glyph3);

endmodule

// File: src/motor_planner.sv
// ##########################################################
// Motor planner
// Wheel directions for dodge style and Bluetooth driving
// ##########################################################

`timescale 1ns/1ns

module motor_planner (
    input  useless_pkg::mode_t     mode,
    input  useless_pkg::ub_style_t style,
    input  useless_pkg::dist_t     dist_left,
    input  useless_pkg::dist_t     dist_right,
    input  logic                   cmd_forward,
    input  logic                   cmd_backward,
    input  logic                   cmd_left,
    input  logic                   cmd_right,
    input  logic                   ble_err,
    output logic [1:0]             motor_cw,
    output logic [1:0]             motor_ccw
);

    import useless_pkg::*;

    dist_ext_t left_ext;
    dist_ext_t right_skew;
    logic      dodge_stop;
    logic      dodge_dir;

    // Per motor, bit 0 left and bit 1 right
    logic [1:0] mot_en;
    logic [1:0] mot_dir;

    assign left_ext   = {1'b0, dist_left};
    assign right_skew = skew_dist(dist_right);

    // Too close on either side, or hand gone on both
    assign dodge_stop = (left_ext < dist_ext_t'(DODGE_NEAR)) ||
                        (right_skew < dist_ext_t'(DODGE_NEAR)) ||
                        ((left_ext > dist_ext_t'(DODGE_FAR)) &&
                         (right_skew > dist_ext_t'(DODGE_FAR)));

    // High when the hand is nearer the left side
    assign dodge_dir = !(left_ext > right_skew);

    always_comb begin
        mot_en  = 2'b00;
        mot_dir = 2'b00;
        if ((mode == MODE_UB) && (style == UB_DODGE)) begin
            if (!dodge_stop) begin
                mot_en  = 2'b11;
                mot_dir = {dodge_dir, dodge_dir};
            end
        end else if ((mode == MODE_UC) && !ble_err) begin
            // Forward wins over the others
            if (cmd_forward) begin
                mot_en  = 2'b11;
                mot_dir = 2'b11;
            end else if (cmd_backward) begin
                mot_en  = 2'b11;
                mot_dir = 2'b00;
            end else if (cmd_left) begin
                // Pivot on the left wheel
                mot_en  = 2'b10;
                mot_dir = 2'b10;
            end else if (cmd_right) begin
                mot_en  = 2'b01;
                mot_dir = 2'b01;
            end
        end
    end

    // Direction high spins cw, low spins ccw
    assign motor_cw  = mot_en & mot_dir;
    assign motor_ccw = mot_en & ~mot_dir;

    // Driver bridge must never see both legs on
    always_comb begin
        a_no_shoot: assert ((motor_cw & motor_ccw) == 2'b00)
            else $error("motor driven cw and ccw together");
    end

endmodule

// File: src/servo_planner.sv
// ##########################################################
// Servo planner
// Tracks the commanded switch position and picks servo
// enable, side and lift amount for each mode and style
// ##########################################################

`timescale 1ns/1ns

module servo_planner (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   sw0,
    input  logic                   cmd_switch,
    input  logic                   ble_err,
    input  useless_pkg::mode_t     mode,
    input  useless_pkg::ub_style_t style,
    input  logic [3:0]             ir_near,
    input  useless_pkg::dist_t     dist_left,
    input  useless_pkg::dist_t     dist_right,
    output logic                   servo_enable,
    output logic                   servo_sel,
    output useless_pkg::servo_amt_t servo_amount
);

    import useless_pkg::*;

    // Box's own idea of where the switch should be
    logic       sw_cmd;
    logic       flip_pending;
    logic       flip_style;

    dist_ext_t  left_ext;
    dist_ext_t  right_skew;
    dist_ext_t  near_dist;
    logic [22:0] lift_raw;
    servo_amt_t closer_amt;

    // Bluetooth toggle, honoured only in NS without link error
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sw_cmd <= sw0;
        end else if ((mode == MODE_NS) && cmd_switch && !ble_err) begin
            sw_cmd <= ~sw_cmd;
        end
    end

    assign flip_pending = (sw_cmd != sw0);
    assign flip_style   = (style == UB_CLASSIC) || (style == UB_ADVANCE);

    // Closer effect, arm rises as the hand approaches
    assign left_ext   = {1'b0, dist_left};
    assign right_skew = skew_dist(dist_right);
    assign near_dist  = (left_ext > right_skew) ? right_skew : left_ext;
    assign lift_raw   = near_dist * SERVO_GAIN;

    always_comb begin
        if (|ir_near) begin
            // Hand right at the box
            closer_amt = SERVO_FULL;
        end else if ((left_ext > dist_ext_t'(GOOD_DIS)) &&
                     (right_skew > dist_ext_t'(GOOD_DIS))) begin
            // Nobody around
            closer_amt = '0;
        end else if (lift_raw < 23'(SERVO_LIMIT)) begin
            closer_amt = servo_amt_t'(lift_raw);
        end else begin
            // Saturate to full lift
            closer_amt = SERVO_FULL;
        end
    end

    always_comb begin
        if (flip_pending) begin
            servo_enable = 1'b1;
            if ((mode == MODE_NS) || ((mode == MODE_UB) && flip_style)) begin
                // Push the switch back, full stroke
                servo_sel    = ~sw0;
                servo_amount = SERVO_FULL;
            end else begin
                // Dodge, invalid or UC, arm stays parked
                servo_sel    = sw0;
                servo_amount = '0;
            end
        end else if (mode == MODE_UB) begin
            servo_enable = 1'b1;
            if (style == UB_ADVANCE) begin
                servo_sel    = ~sw0;
                servo_amount = closer_amt;
            end else begin
                servo_sel    = sw0;
                servo_amount = '0;
            end
        end else begin
            // Idle in NS and UC
            servo_enable = 1'b0;
            servo_sel    = ~sw0;
            servo_amount = '0;
        end
    end

    // Arm never lifts while the servo is disabled
    a_amt_idle: assert property (
        @(posedge clk) disable iff (rst) !servo_enable |-> (servo_amount == '0)
    ) else $error("servo amount nonzero while servo disabled");

endmodule

// File: src/mode_decoder.sv
// ##########################################################
// Mode decoder
// Steps NS -> UB -> UC on each pulse, decodes the UB style
// selection and drives the relay
// ##########################################################

`timescale 1ns/1ns

module mode_decoder (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  mode_pulse,
    input  useless_pkg::ub_sel_t  wanted_ub,
    input  logic                  sw0,
    output useless_pkg::mode_t    mode,
    output useless_pkg::ub_style_t style,
    output logic                  sel_err,
    output logic                  relay
);

    import useless_pkg::*;

    mode_t mode_q;
    mode_t mode_next;

    // Next mode in the cycle, UC wraps to NS
    always_comb begin
        case (mode_q)
            MODE_NS: mode_next = MODE_UB;
            MODE_UB: mode_next = MODE_UC;
            default: mode_next = MODE_NS;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode_q <= MODE_NS;
        end else if (mode_pulse) begin
            mode_q <= mode_next;
        end
    end

    assign mode = mode_q;

    // One-hot selection, anything else is an error
    always_comb begin
        case (wanted_ub)
            3'b001:  style = UB_CLASSIC;
            3'b010:  style = UB_DODGE;
            3'b100:  style = UB_ADVANCE;
            // 000 included, no random style here
            default: style = UB_INVALID;
        endcase
    end

    assign sel_err = (style == UB_INVALID);

    // Relay only follows the switch in plain NS
    assign relay = (mode_q == MODE_NS) ? sw0 : 1'b0;

    // Mode register never reaches the spare code
    a_mode_legal: assert property (
        @(posedge clk) disable iff (rst) mode_q != 2'd3
    ) else $error("mode register holds unused code 3");

endmodule

// File: src/useless_pkg.sv
// ##########################################################
// Useless box shared types and tuning constants
// Mode and style enums, field widths, distance thresholds
// ##########################################################

package useless_pkg;

    // Mode state machine, code 3 is unused
    typedef enum logic [1:0] {
        MODE_NS = 2'd0,
        MODE_UB = 2'd1,
        MODE_UC = 2'd2
    } mode_t;

    // Decoded useless-box behaviour
    typedef enum logic [1:0] {
        UB_CLASSIC = 2'd0,
        UB_DODGE   = 2'd1,
        UB_ADVANCE = 2'd2,
        UB_INVALID = 2'd3
    } ub_style_t;

    typedef logic [2:0]  ub_sel_t;
    // Distance in cm
    typedef logic [19:0] dist_t;
    // One extra bit so the skewed reading cannot wrap
    typedef logic [20:0] dist_ext_t;
    typedef logic [4:0]  servo_amt_t;
    typedef logic [3:0]  glyph_t;
    // Segments g..a, active low
    typedef logic [6:0]  seg_t;

    // Hand considered absent beyond this
    localparam dist_t GOOD_DIS = 20'd20;
    // Right sensor sits closer, box is not symmetric
    localparam dist_t DIST_SKEW = 20'd4;

    localparam servo_amt_t SERVO_FULL  = 5'd31;
    localparam servo_amt_t SERVO_LIMIT = 5'd25;
    localparam logic [1:0] SERVO_GAIN  = 2'd3;

    // Dodge stop band edges
    localparam dist_t DODGE_NEAR = 20'd7;
    localparam dist_t DODGE_FAR  = 20'd10;

    localparam glyph_t GLYPH_E     = 4'd11;
    localparam glyph_t GLYPH_R     = 4'd12;
    localparam glyph_t GLYPH_BLANK = 4'd15;

    // Right reading corrected for the skew
    function automatic dist_ext_t skew_dist(input dist_t d);
        return {1'b0, d} + {1'b0, DIST_SKEW};
    endfunction

endpackage
